// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: tb/tb_port_group.sv
`timescale 1ns/1ps

module tb_port_group;
    import pg_stream_pkg::*;
    import pg_rule_pkg::*;

    // Three directed packets, 20 free-flowing and 60 under back-pressure
    localparam int NUM_PACKETS    = 83;
    localparam int TIMEOUT_CYCLES = 40 * NUM_PACKETS + 200;

    logic        clk;
    logic        rst;
    meta_t       in_meta_data;
    logic        in_meta_valid;
    logic        in_meta_ready;
    beat_data_t  in_rule_data;
    logic        in_rule_sop;
    logic        in_rule_eop;
    logic        in_rule_valid;
    logic        in_rule_ready;
    beat_data_t  out_rule_data;
    logic        out_rule_sop;
    logic        out_rule_eop;
    logic        out_rule_valid;
    logic        out_rule_ready;
    meta_t       out_meta_data;
    logic        out_meta_valid;
    logic        out_meta_ready;
    logic [31:0] stats_beats_checked;
    logic [31:0] stats_beats_kept;

    logic [15:0] data_lfsr;
    logic [15:0] ready_lfsr;
    logic        bp_enable;
    beat_data_t  pkt_beats [4];
    rule_word_t  exp_beat_q [$];
    meta_t       exp_meta_q [$];
    rule_word_t  exp_word;
    meta_t       exp_meta;
    int          error_count;
    int          check_total;
    int          exp_checked;
    int          exp_kept;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;

    tb_clock i_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    port_group i_port_group (
        .clk                 (clk),
        .rst                 (rst),
        .in_meta_data        (in_meta_data),
        .in_meta_valid       (in_meta_valid),
        .in_meta_ready       (in_meta_ready),
        .in_rule_data        (in_rule_data),
        .in_rule_sop         (in_rule_sop),
        .in_rule_eop         (in_rule_eop),
        .in_rule_valid       (in_rule_valid),
        .in_rule_ready       (in_rule_ready),
        .out_rule_data       (out_rule_data),
        .out_rule_sop        (out_rule_sop),
        .out_rule_eop        (out_rule_eop),
        .out_rule_valid      (out_rule_valid),
        .out_rule_ready      (out_rule_ready),
        .out_meta_data       (out_meta_data),
        .out_meta_valid      (out_meta_valid),
        .out_meta_ready      (out_meta_ready),
        .stats_beats_checked (stats_beats_checked),
        .stats_beats_kept    (stats_beats_kept)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            data_lfsr = lfsr_next(data_lfsr);
            v = {v[14:0], data_lfsr[0]};
        end
    endtask

    function automatic beat_data_t make_beat(input logic [7:0] s0, input logic [7:0] s1,
                                             input logic [7:0] s2, input logic [7:0] s3);
        beat_data_t r;
        r = '0;
        r[0*SLOT_WIDTH +: 8] = s0;
        r[1*SLOT_WIDTH +: 8] = s1;
        r[2*SLOT_WIDTH +: 8] = s2;
        r[3*SLOT_WIDTH +: 8] = s3;
        return r;
    endfunction

    // An ID survives on protocol plus either port
    function automatic beat_data_t expected_beat(input meta_t m, input beat_data_t beat);
        rule_entry_t e;
        logic [7:0]  id;
        logic        tcp_pkt;
        beat_data_t  r;
        r = '0;
        tcp_pkt = (m.prot == PROT_TCP);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            id = beat[s*SLOT_WIDTH +: 8];
            e  = rule_table_entry(id);
            if (id != 8'd0 && e.tcp == tcp_pkt
                && (e.port == m.src_port || e.port == m.dst_port)) begin
                r[s*SLOT_WIDTH +: 8] = id;
            end
        end
        return r;
    endfunction

    task automatic model_packet(input meta_t m, input int len);
        rule_word_t w;
        logic       first;
        beat_data_t d;
        logic       last;
        first = 1'b1;
        for (int b = 0; b < len; b++) begin
            d    = expected_beat(m, pkt_beats[b]);
            last = (b == len - 1);
            if (!last) begin
                exp_checked++;
            end
            if (d != '0 || last) begin
                w.data = d;
                w.sop  = first;
                w.eop  = last;
                exp_beat_q.push_back(w);
                first = 1'b0;
                if (!last) begin
                    exp_kept++;
                end
            end
        end
        exp_meta_q.push_back(m);
    endtask

    task automatic random_packet(output meta_t m, output int len);
        logic [15:0] v;
        logic        tcp_pkt;
        logic [7:0]  ida;
        logic [7:0]  idb;
        logic [7:0]  id;
        rand_bits(2, v);
        len = int'(v[1:0]) + 1;
        rand_bits(1, v);
        tcp_pkt = v[0];
        // Port IDs take the parity that their protocol needs
        rand_bits(7, v);
        ida = {v[6:0], ~tcp_pkt};
        rand_bits(7, v);
        idb = {v[6:0], ~tcp_pkt};
        m.src_port = 16'd1000 + {8'h00, ida};
        m.dst_port = 16'd1000 + {8'h00, idb};
        m.prot     = tcp_pkt ? PROT_TCP : 8'd17;
        for (int b = 0; b < len; b++) begin
            pkt_beats[b] = '0;
            for (int s = 0; s < NUM_SLOTS; s++) begin
                rand_bits(1, v);
                if (v[0]) begin
                    rand_bits(1, v);
                    id = v[0] ? ida : idb;
                end else begin
                    rand_bits(8, v);
                    id = v[7:0];
                end
                pkt_beats[b][s*SLOT_WIDTH +: 8] = id;
            end
        end
    endtask

    // Called 1 ns after a rising edge
    task automatic send_packet(input meta_t m, input int len);
        model_packet(m, len);
        in_meta_data  = m;
        in_meta_valid = 1'b1;
        for (int b = 0; b < len; b++) begin
            in_rule_data  = pkt_beats[b];
            in_rule_sop   = (b == 0);
            in_rule_eop   = (b == len - 1);
            in_rule_valid = 1'b1;
            do @(posedge clk); while (!in_rule_ready);
            #1;
        end
        in_rule_valid = 1'b0;
        do @(posedge clk); while (!in_meta_ready);
        #1;
        in_meta_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_beat_q.size() != 0 || exp_meta_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic set_backpressure(input logic en);
        @(negedge clk);
        bp_enable = en;
        @(posedge clk);
        #1;
    endtask

    task automatic check_beat(input beat_data_t data, input logic sop, input logic eop,
                              input rule_word_t exp);
        check_total++;
        if (data !== exp.data || sop !== exp.sop || eop !== exp.eop) begin
            $display("error at %0t: beat %h sop %b eop %b, expected %h sop %b eop %b",
                     $time, data, sop, eop, exp.data, exp.sop, exp.eop);
            error_count++;
        end
    endtask

    task automatic check_meta(input meta_t got, input meta_t exp);
        check_total++;
        if (got !== exp) begin
            $display("error at %0t: metadata %h, expected %h", $time, got, exp);
            error_count++;
        end
    endtask

    task automatic check_count(input logic [31:0] got, input logic [31:0] exp,
                               input string name);
        check_total++;
        if (got !== exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        if (error_count == errs) begin
            tests_passed++;
            $display("test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, error_count - errs);
        end
    endtask

    always @(posedge clk) begin
        #1;
        if (bp_enable) begin
            ready_lfsr     = lfsr_next(ready_lfsr);
            out_rule_ready = ready_lfsr[0];
            ready_lfsr     = lfsr_next(ready_lfsr);
            out_meta_ready = ready_lfsr[0];
        end else begin
            out_rule_ready = 1'b1;
            out_meta_ready = 1'b1;
        end
    end

    // Output compare
    always @(posedge clk) begin
        if (!rst && out_rule_valid && out_rule_ready) begin
            if (exp_beat_q.size() == 0) begin
                $display("unexpected rule beat at the output at %0t, none was due", $time);
                error_count++;
            end else begin
                exp_word = exp_beat_q.pop_front();
                check_beat(out_rule_data, out_rule_sop, out_rule_eop, exp_word);
            end
        end
        if (!rst && out_meta_valid && out_meta_ready) begin
            if (exp_meta_q.size() == 0) begin
                $display("unexpected metadata record at the output at %0t", $time);
                error_count++;
            end else begin
                exp_meta = exp_meta_q.pop_front();
                check_meta(out_meta_data, exp_meta);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        meta_t m;
        int    len;
        int    errs;
        data_lfsr      = 16'd69;
        ready_lfsr     = 16'd69;
        bp_enable      = 1'b0;
        error_count    = 0;
        check_total    = 0;
        exp_checked    = 0;
        exp_kept       = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        cycle_count    = 0;
        in_meta_data   = '0;
        in_meta_valid  = 1'b0;
        in_rule_data   = '0;
        in_rule_sop    = 1'b0;
        in_rule_eop    = 1'b0;
        in_rule_valid  = 1'b0;
        out_rule_ready = 1'b1;
        out_meta_ready = 1'b1;
        do @(posedge clk); while (rst);
        #1;

        errs       = error_count;
        m.src_port = 16'd1010;
        m.dst_port = 16'd1020;
        m.prot     = PROT_TCP;
        pkt_beats[0] = make_beat(8'd10, 8'd20, 8'd11, 8'd0);
        pkt_beats[1] = make_beat(8'd30, 8'd10, 8'd0, 8'd20);
        send_packet(m, 2);
        wait_drain();
        report_test(1, "slot filtering", errs);

        // Leading beat fails, trailing eop beat fails
        errs       = error_count;
        m.src_port = 16'd1007;
        m.dst_port = 16'd1009;
        m.prot     = 8'd17;
        pkt_beats[0] = make_beat(8'd8, 8'd2, 8'd0, 8'd100);
        pkt_beats[1] = make_beat(8'd7, 8'd0, 8'd9, 8'd3);
        pkt_beats[2] = make_beat(8'd0, 8'd0, 8'd0, 8'd5);
        send_packet(m, 3);
        wait_drain();
        report_test(2, "beat drop and sop rebuild", errs);

        errs       = error_count;
        m.src_port = 16'd2000;
        m.dst_port = 16'd3000;
        m.prot     = PROT_TCP;
        pkt_beats[0] = make_beat(8'd2, 8'd4, 8'd6, 8'd8);
        pkt_beats[1] = make_beat(8'd10, 8'd12, 8'd0, 8'd14);
        pkt_beats[2] = make_beat(8'd16, 8'd18, 8'd20, 8'd22);
        send_packet(m, 3);
        wait_drain();
        report_test(3, "eop-only survivor", errs);

        errs = error_count;
        for (int p = 0; p < 20; p++) begin
            random_packet(m, len);
            send_packet(m, len);
        end
        wait_drain();
        report_test(4, "metadata order", errs);

        errs = error_count;
        set_backpressure(1'b1);
        for (int p = 0; p < 60; p++) begin
            random_packet(m, len);
            send_packet(m, len);
        end
        wait_drain();
        set_backpressure(1'b0);
        report_test(5, "back-pressure", errs);

        errs = error_count;
        @(negedge clk);
        check_count(stats_beats_checked, exp_checked, "stats_beats_checked");
        check_count(stats_beats_kept, exp_kept, "stats_beats_kept");
        if (out_rule_valid || out_meta_valid) begin
            $display("extra output is still waiting after all expected results arrived");
            error_count++;
        end
        report_test(6, "statistics", errs);

        $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_total, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
verilog/pg_stream_pkg.sv
verilog/pg_rule_pkg.sv
verilog/stream_fifo.sv
verilog/rule_lane.sv
verilog/rule_dispatch.sv
verilog/rule_compactor.sv
verilog/port_group.sv
tb/tb_clock.sv
tb/tb_port_group.sv

// File: verilog/pg_rule_pkg.sv
package pg_rule_pkg;

    localparam int RULE_ID_WIDTH = 8;
    localparam int RULE_DEPTH    = 2 ** RULE_ID_WIDTH;

    // Table read plus compare
    localparam int LANE_LATENCY = 2;

    localparam logic [15:0] RULE_PORT_BASE = 16'd1000;

    typedef logic [RULE_ID_WIDTH-1:0] rule_id_t;

    typedef struct packed {
        logic        tcp;
        logic [15:0] port;
    } rule_entry_t;

    // Even IDs are TCP rules
    function automatic rule_entry_t rule_table_entry(input rule_id_t id);
        rule_entry_t entry;
        if (id == '0) begin
            entry.tcp  = 1'b0;
            entry.port = 16'd0;
        end else begin
            entry.tcp  = ~id[0];
            entry.port = RULE_PORT_BASE + 16'(id);
        end
        return entry;
    endfunction

endpackage

// File: verilog/pg_stream_pkg.sv
package pg_stream_pkg;

    localparam int SLOT_WIDTH = 16;
    localparam int NUM_SLOTS  = 4;
    localparam int BEAT_WIDTH = SLOT_WIDTH * NUM_SLOTS;

    typedef logic [BEAT_WIDTH-1:0] beat_data_t;

    // Per-packet record
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [7:0]  prot;
    } meta_t;

    localparam logic [7:0] PROT_TCP = 8'd6;

    // Rule FIFO payload
    typedef struct packed {
        beat_data_t data;
        logic       sop;
        logic       eop;
    } rule_word_t;

    localparam int FIFO_DEPTH     = 32;
    localparam int AFULL_SLACK    = 6;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

endpackage

// File: verilog/port_group.sv
`timescale 1ns/1ps

module port_group (
    input  logic                      clk,
    input  logic                      rst,

    input  pg_stream_pkg::meta_t      in_meta_data,
    input  logic                      in_meta_valid,
    output logic                      in_meta_ready,

    input  pg_stream_pkg::beat_data_t in_rule_data,
    input  logic                      in_rule_sop,
    input  logic                      in_rule_eop,
    input  logic                      in_rule_valid,
    output logic                      in_rule_ready,

    output pg_stream_pkg::beat_data_t out_rule_data,
    output logic                      out_rule_sop,
    output logic                      out_rule_eop,
    output logic                      out_rule_valid,
    input  logic                      out_rule_ready,

    output pg_stream_pkg::meta_t      out_meta_data,
    output logic                      out_meta_valid,
    input  logic                      out_meta_ready,

    output logic [31:0]               stats_beats_checked,
    output logic [31:0]               stats_beats_kept
);
    import pg_stream_pkg::*;
    import pg_rule_pkg::*;

    logic                            rule_afull;
    logic                            meta_afull;
    logic                            meta_push;
    logic [15:0]                     src_port;
    logic [15:0]                     dst_port;
    logic                            tcp;
    rule_id_t [NUM_SLOTS-1:0]        lane_ids;
    rule_id_t [NUM_SLOTS-1:0]        lane_slots;
    logic                            beat_valid;
    logic                            beat_eop;
    logic                            fifo_push;
    rule_word_t                      fifo_word;
    rule_word_t                      rule_out_word;

    // Input sop is rebuilt by the compactor after dropping beats
    rule_dispatch i_rule_dispatch (
        .clk           (clk),
        .rst           (rst),
        .in_meta_data  (in_meta_data),
        .in_meta_valid (in_meta_valid),
        .in_meta_ready (in_meta_ready),
        .in_rule_data  (in_rule_data),
        .in_rule_eop   (in_rule_eop),
        .in_rule_valid (in_rule_valid),
        .in_rule_ready (in_rule_ready),
        .rule_afull    (rule_afull),
        .meta_afull    (meta_afull),
        .src_port      (src_port),
        .dst_port      (dst_port),
        .tcp           (tcp),
        .lane_ids      (lane_ids),
        .beat_valid    (beat_valid),
        .beat_eop      (beat_eop),
        .meta_push     (meta_push)
    );

    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_lane
        rule_lane i_rule_lane (
            .clk      (clk),
            .src_port (src_port),
            .dst_port (dst_port),
            .tcp      (tcp),
            .rule_id  (lane_ids[g]),
            .slot_out (lane_slots[g])
        );
    end

    rule_compactor i_rule_compactor (
        .clk                 (clk),
        .rst                 (rst),
        .lane_slots          (lane_slots),
        .beat_valid          (beat_valid),
        .beat_eop            (beat_eop),
        .fifo_push           (fifo_push),
        .fifo_word           (fifo_word),
        .stats_beats_checked (stats_beats_checked),
        .stats_beats_kept    (stats_beats_kept)
    );

    // Writes are held off upstream by almost_full
    stream_fifo #(
        .T (rule_word_t)
    ) rule_fifo (
        .clk         (clk),
        .rst         (rst),
        .in_data     (fifo_word),
        .in_valid    (fifo_push),
        .in_ready    (),
        .out_data    (rule_out_word),
        .out_valid   (out_rule_valid),
        .out_ready   (out_rule_ready),
        .almost_full (rule_afull)
    );

    stream_fifo #(
        .T (meta_t)
    ) meta_fifo (
        .clk         (clk),
        .rst         (rst),
        .in_data     (in_meta_data),
        .in_valid    (meta_push),
        .in_ready    (),
        .out_data    (out_meta_data),
        .out_valid   (out_meta_valid),
        .out_ready   (out_meta_ready),
        .almost_full (meta_afull)
    );

    assign out_rule_data = rule_out_word.data;
    assign out_rule_sop  = rule_out_word.sop;
    assign out_rule_eop  = rule_out_word.eop;

endmodule

// File: verilog/rule_compactor.sv
`timescale 1ns/1ps

module rule_compactor (
    input  logic                      clk,
    input  logic                      rst,
    input  pg_rule_pkg::rule_id_t [pg_stream_pkg::NUM_SLOTS-1:0] lane_slots,
    input  logic                      beat_valid,
    input  logic                      beat_eop,
    output logic                      fifo_push,
    output pg_stream_pkg::rule_word_t fifo_word,
    output logic [31:0]               stats_beats_checked,
    output logic [31:0]               stats_beats_kept
);
    import pg_stream_pkg::*;
    import pg_rule_pkg::*;

    logic [LANE_LATENCY-1:0] valid_sr;
    logic [LANE_LATENCY-1:0] eop_sr;
    logic                    res_valid;
    logic                    res_eop;
    logic                    any_hit;
    logic                    keep;
    logic                    mid_pkt;
    beat_data_t              res_data;

    // Line up beat flags with the lane results
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
            eop_sr   <= '0;
        end else begin
            valid_sr <= (valid_sr << 1) | LANE_LATENCY'(beat_valid);
            eop_sr   <= (eop_sr << 1) | LANE_LATENCY'(beat_eop);
        end
    end

    assign res_valid = valid_sr[LANE_LATENCY-1];
    assign res_eop   = eop_sr[LANE_LATENCY-1];

    always_comb begin
        res_data = '0;
        any_hit  = 1'b0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            res_data[s*SLOT_WIDTH +: RULE_ID_WIDTH] = lane_slots[s];
            any_hit = any_hit | (lane_slots[s] != '0);
        end
    end

    // Last beat always goes out so the packet closes
    assign keep = res_valid && (any_hit || res_eop);

    always_ff @(posedge clk) begin
        if (rst) begin
            fifo_push           <= 1'b0;
            mid_pkt             <= 1'b0;
            stats_beats_checked <= '0;
            stats_beats_kept    <= '0;
        end else begin
            fifo_push <= keep;
            if (keep) begin
                mid_pkt <= !res_eop;
            end
            if (res_valid && !res_eop) begin
                stats_beats_checked <= stats_beats_checked + 1'b1;
            end
            if (keep && !res_eop) begin
                stats_beats_kept <= stats_beats_kept + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        fifo_word.data <= res_data;
        fifo_word.sop  <= !mid_pkt;
        fifo_word.eop  <= res_eop;
    end

endmodule

// File: verilog/rule_dispatch.sv
`timescale 1ns/1ps

module rule_dispatch (
    input  logic                      clk,
    input  logic                      rst,
    input  pg_stream_pkg::meta_t      in_meta_data,
    input  logic                      in_meta_valid,
    output logic                      in_meta_ready,
    input  pg_stream_pkg::beat_data_t in_rule_data,
    input  logic                      in_rule_eop,
    input  logic                      in_rule_valid,
    output logic                      in_rule_ready,
    input  logic                      rule_afull,
    input  logic                      meta_afull,
    output logic [15:0]               src_port,
    output logic [15:0]               dst_port,
    output logic                      tcp,
    output pg_rule_pkg::rule_id_t [pg_stream_pkg::NUM_SLOTS-1:0] lane_ids,
    output logic                      beat_valid,
    output logic                      beat_eop,
    output logic                      meta_push
);
    import pg_stream_pkg::*;
    import pg_rule_pkg::*;

    typedef enum logic {
        IDLE,
        RULE
    } state_t;

    state_t state;
    logic   start;
    logic   accept;

    // Record still shows valid during its consume pulse
    assign start = (state == IDLE) && in_meta_valid && !in_meta_ready
                   && !rule_afull && !meta_afull;

    assign in_rule_ready = (state == RULE) && !rule_afull;
    assign accept        = in_rule_valid && in_rule_ready;
    assign meta_push     = in_meta_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            beat_valid    <= 1'b0;
            beat_eop      <= 1'b0;
            in_meta_ready <= 1'b0;
        end else begin
            beat_valid    <= accept;
            beat_eop      <= accept && in_rule_eop;
            in_meta_ready <= accept && in_rule_eop;
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RULE;
                    end
                end
                RULE: begin
                    if (accept && in_rule_eop) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Packet fields held for the whole packet
    always_ff @(posedge clk) begin
        if (start) begin
            src_port <= in_meta_data.src_port;
            dst_port <= in_meta_data.dst_port;
            tcp      <= (in_meta_data.prot == PROT_TCP);
        end
        if (accept) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                lane_ids[s] <= in_rule_data[s*SLOT_WIDTH +: RULE_ID_WIDTH];
            end
        end
    end

endmodule

// File: verilog/rule_lane.sv
`timescale 1ns/1ps

module rule_lane (
    input  logic                  clk,
    input  logic [15:0]           src_port,
    input  logic [15:0]           dst_port,
    input  logic                  tcp,
    input  pg_rule_pkg::rule_id_t rule_id,
    output pg_rule_pkg::rule_id_t slot_out
);
    import pg_rule_pkg::*;

    rule_entry_t table_mem [RULE_DEPTH];
    rule_entry_t entry_q;
    rule_id_t    id_q;
    logic        port_hit;
    logic        hit;

    // Local copy of the port-group table
    initial begin
        for (int i = 0; i < RULE_DEPTH; i++) begin
            table_mem[i] = rule_table_entry(rule_id_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        entry_q <= table_mem[rule_id];
        id_q    <= rule_id;
    end

    assign port_hit = (entry_q.port == src_port) || (entry_q.port == dst_port);
    assign hit      = port_hit && (entry_q.tcp == tcp) && (id_q != '0);

    // Failing rule reads as zero
    always_ff @(posedge clk) begin
        slot_out <= hit ? id_q : '0;
    end

endmodule

// File: verilog/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter type T = logic [7:0]
) (
    input  logic clk,
    input  logic rst,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready,
    output logic almost_full
);
    import pg_stream_pkg::*;

    T                          mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_CNT_WIDTH-1:0] count;
    logic                      wr_en;
    logic                      rd_en;

    assign in_ready  = (count != FIFO_CNT_WIDTH'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    // Show-ahead read of the head entry
    assign out_data = mem[rd_ptr];

    // Fewer than AFULL_SLACK free entries
    assign almost_full = (count > FIFO_CNT_WIDTH'(FIFO_DEPTH - AFULL_SLACK));

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule
